/* hw/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Cache geometry

// Number of ways, also the width of every way mask
`define ICACHE_WAYS 4

// Sets per way
`define ICACHE_SETS 16

// 32-bit words per line
`define ICACHE_LINE_WORDS 4

// Byte address width of the fetch and bus sides
`define ICACHE_ADDR_W 32

`endif

/* hw/icache_lookup.sv */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_lookup (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	input  icache_pkg::addr_t     req_addr,
	output logic                  req_ready,
	input  logic                  stage_done,
	input  logic                  line_filled,
	output logic                  stage_valid,
	output icache_pkg::tag_t      stage_tag,
	output icache_pkg::index_t    stage_index,
	output icache_pkg::word_sel_t stage_word,
	output icache_pkg::way_mask_t victim
);

	// Low bit of each address field
	localparam int WORD_LO  = 2;
	localparam int INDEX_LO = WORD_LO + icache_pkg::WORD_W;
	localparam int TAG_LO   = INDEX_LO + icache_pkg::INDEX_W;

	logic accept;

	// Stage frees up in the same cycle its response completes
	assign req_ready = !(stage_valid && !stage_done);
	assign accept    = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid <= 1'b0;
		end else if (accept) begin
			stage_valid <= 1'b1;  // Back-to-back requests keep it set
		end else if (stage_done) begin
			stage_valid <= 1'b0;
		end
	end

	// Accepted address split into tag, set and word
	always_ff @(posedge clk) begin
		if (accept) begin
			stage_tag   <= req_addr[`ICACHE_ADDR_W-1:TAG_LO];
			stage_index <= req_addr[TAG_LO-1:INDEX_LO];
			stage_word  <= req_addr[INDEX_LO-1:WORD_LO];
		end
	end

	// Round-robin victim, one step per completed refill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= icache_pkg::way_mask_t'(1);  // Way 0 first
		end else if (line_filled) begin
			victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
		end
	end

endmodule

/* hw/icache_pkg.sv */
`include "icache_cfg.svh"

package icache_pkg;

	// Field widths of a byte address
	localparam int WORD_W  = $clog2(`ICACHE_LINE_WORDS);  // Word within the line
	localparam int INDEX_W = $clog2(`ICACHE_SETS);        // Set number
	localparam int TAG_W   = `ICACHE_ADDR_W - INDEX_W - WORD_W - 2;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;      // Byte address
	typedef logic [31:0]               inst_t;      // Instruction word
	typedef logic [TAG_W-1:0]          tag_t;       // Address bits above the index
	typedef logic [INDEX_W-1:0]        index_t;     // Address bits 7:4
	typedef logic [WORD_W-1:0]         word_sel_t;  // Address bits 3:2
	typedef logic [`ICACHE_WAYS-1:0]   way_mask_t;  // One-hot or hit vector

	// Miss engine states
	typedef enum logic {
		RF_IDLE,
		RF_FETCH
	} refill_state_t;

endpackage

/* hw/icache_refill.sv */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_refill (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stage_valid,
	input  icache_pkg::tag_t      stage_tag,
	input  icache_pkg::index_t    stage_index,
	input  icache_pkg::way_mask_t way_hit,
	input  icache_pkg::inst_t     way_words [`ICACHE_WAYS],
	input  icache_pkg::way_mask_t victim,
	output logic                  resp_valid,
	output icache_pkg::inst_t     resp_inst,
	input  logic                  resp_ready,
	output logic                  stage_done,
	output logic                  line_filled,
	output icache_pkg::way_mask_t fill_mask,
	output icache_pkg::word_sel_t fill_word_sel,
	output icache_pkg::inst_t     fill_data,
	output logic                  fill_last,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output icache_pkg::addr_t     wb_adr,
	input  logic                  wb_ack,
	input  icache_pkg::inst_t     wb_dat_r
);

	icache_pkg::refill_state_t state_q;
	icache_pkg::way_mask_t     victim_q;     // Way being filled
	icache_pkg::word_sel_t     beat_q;       // Line word on the bus
	icache_pkg::inst_t         hit_word;
	icache_pkg::inst_t         hold_inst_q;
	logic                      hold_q;       // Answer parked while the core stalls
	logic                      hit_any;
	logic                      miss;
	logic                      fetching;
	logic                      beat_done;

	// Hit vector is one-hot, so an OR of masked words is the mux
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < `ICACHE_WAYS; i++) begin
			if (way_hit[i]) begin
				hit_word = hit_word | way_words[i];
			end
		end
	end

	assign hit_any    = |way_hit;
	assign resp_valid = stage_valid && (hit_any || hold_q);
	assign resp_inst  = hold_q ? hold_inst_q : hit_word;
	assign stage_done = resp_valid && resp_ready;
	assign miss       = stage_valid && !hit_any && !hold_q;

	// Once offered, the answer stays put even if a flush drops the line
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_q <= 1'b0;
		end else if (stage_done) begin
			hold_q <= 1'b0;
		end else if (resp_valid) begin
			hold_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_valid && !hold_q) begin
			hold_inst_q <= hit_word;
		end
	end

	// Miss engine
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= icache_pkg::RF_IDLE;
			victim_q <= '0;
			beat_q   <= '0;
		end else begin
			case (state_q)
				icache_pkg::RF_IDLE: begin
					if (miss) begin
						state_q  <= icache_pkg::RF_FETCH;
						victim_q <= victim;
						beat_q   <= '0;  // Start at the line base
					end
				end
				icache_pkg::RF_FETCH: begin
					if (wb_ack) begin
						beat_q <= beat_q + 1'b1;
						if (fill_last) begin
							state_q <= icache_pkg::RF_IDLE;
						end
					end
				end
			endcase
		end
	end

	assign fetching  = (state_q == icache_pkg::RF_FETCH);
	assign beat_done = fetching && wb_ack;

	// Classic cycle held for the whole line
	assign wb_cyc = fetching;
	assign wb_stb = fetching;
	assign wb_adr = {stage_tag, stage_index, beat_q, 2'b00};

	// Each acked word goes straight into the victim way
	assign fill_mask     = beat_done ? victim_q : '0;
	assign fill_word_sel = beat_q;
	assign fill_data     = wb_dat_r;
	assign fill_last     = beat_done &&
		(beat_q == icache_pkg::word_sel_t'(`ICACHE_LINE_WORDS - 1));
	assign line_filled   = fill_last;  // Also steps the victim pointer

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              flush,
	input  logic              req_valid,
	input  icache_pkg::addr_t req_addr,
	output logic              req_ready,
	output logic              resp_valid,
	output icache_pkg::inst_t resp_inst,
	input  logic              resp_ready,
	output logic              wb_cyc,
	output logic              wb_stb,
	output icache_pkg::addr_t wb_adr,
	input  logic              wb_ack,
	input  icache_pkg::inst_t wb_dat_r
);

	logic                  stage_valid;
	icache_pkg::tag_t      stage_tag;
	icache_pkg::index_t    stage_index;
	icache_pkg::word_sel_t stage_word;
	icache_pkg::way_mask_t victim;
	icache_pkg::way_mask_t way_hit;
	icache_pkg::inst_t     way_words [`ICACHE_WAYS];
	logic                  stage_done;
	logic                  line_filled;
	icache_pkg::way_mask_t fill_mask;
	icache_pkg::word_sel_t fill_word_sel;
	icache_pkg::inst_t     fill_data;
	logic                  fill_last;

	icache_lookup u_lookup (
		.clk         (clk),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.req_ready   (req_ready),
		.stage_done  (stage_done),
		.line_filled (line_filled),
		.stage_valid (stage_valid),
		.stage_tag   (stage_tag),
		.stage_index (stage_index),
		.stage_word  (stage_word),
		.victim      (victim)
	);

	genvar i;
	generate
		for (i = 0; i < `ICACHE_WAYS; i++) begin : g_way
			icache_way u_way (
				.clk           (clk),
				.rst           (rst),
				.flush         (flush),
				.stage_tag     (stage_tag),
				.stage_index   (stage_index),
				.stage_word    (stage_word),
				.fill_en       (fill_mask[i]),  // Only the victim way writes
				.fill_word_sel (fill_word_sel),
				.fill_data     (fill_data),
				.fill_last     (fill_last),
				.hit           (way_hit[i]),
				.rd_word       (way_words[i])
			);
		end
	endgenerate

	icache_refill u_refill (
		.clk           (clk),
		.rst           (rst),
		.stage_valid   (stage_valid),
		.stage_tag     (stage_tag),
		.stage_index   (stage_index),
		.way_hit       (way_hit),
		.way_words     (way_words),
		.victim        (victim),
		.resp_valid    (resp_valid),
		.resp_inst     (resp_inst),
		.resp_ready    (resp_ready),
		.stage_done    (stage_done),
		.line_filled   (line_filled),
		.fill_mask     (fill_mask),
		.fill_word_sel (fill_word_sel),
		.fill_data     (fill_data),
		.fill_last     (fill_last),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_adr        (wb_adr),
		.wb_ack        (wb_ack),
		.wb_dat_r      (wb_dat_r)
	);

endmodule

/* hw/icache_way.sv */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_way (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  flush,
	input  icache_pkg::tag_t      stage_tag,
	input  icache_pkg::index_t    stage_index,
	input  icache_pkg::word_sel_t stage_word,
	input  logic                  fill_en,
	input  icache_pkg::word_sel_t fill_word_sel,
	input  icache_pkg::inst_t     fill_data,
	input  logic                  fill_last,
	output logic                  hit,
	output icache_pkg::inst_t     rd_word
);

	icache_pkg::tag_t        tag_mem  [`ICACHE_SETS];
	icache_pkg::inst_t       data_mem [`ICACHE_SETS][`ICACHE_LINE_WORDS];
	logic [`ICACHE_SETS-1:0] valid_q;

	// Compare against the staged address
	assign hit     = valid_q[stage_index] && (tag_mem[stage_index] == stage_tag);
	assign rd_word = data_mem[stage_index][stage_word];  // Asynchronous word read

	// Line fill, one word per acked beat
	always_ff @(posedge clk) begin
		if (fill_en) begin
			data_mem[stage_index][fill_word_sel] <= fill_data;
			if (fill_last) begin
				tag_mem[stage_index] <= stage_tag;  // Tag goes in with the last word
			end
		end
	end

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			if (flush) begin
				valid_q <= '0;
			end
			// A final beat in the flush edge still marks its own line
			if (fill_en && fill_last) begin
				valid_q[stage_index] <= 1'b1;
			end
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the icache testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert --top-module icache_tb -f vlog.f -o icache_sim \
	&& ./obj_dir/icache_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "icache run: PASS" \
	|| { echo "icache run: FAIL"; exit 1; }

/* test/icache_chk.sv */
`timescale 1ns/1ps

module icache_chk (
	input logic              clk,
	input logic              rst,
	input logic              stage_valid,
	input logic              resp_valid,
	input logic              resp_ready,
	input icache_pkg::inst_t resp_inst,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_ack,
	input icache_pkg::addr_t wb_adr
);

	int fail_count = 0;  // Read by the testbench at the end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high outside a bus cycle");
			fail_count++;
		end

	// Stalled answer must not move
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_inst))
		else begin
			$error("resp_inst or resp_valid changed during a stall");
			fail_count++;
		end

	a_adr_hold: assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> $stable(wb_adr))
		else begin
			$error("wb_adr changed inside a beat");
			fail_count++;
		end

	// A bus cycle opens only for a staged address that did not hit
	a_cyc_cause: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_cyc) |-> $past(stage_valid && !resp_valid))
		else begin
			$error("wb_cyc rose without a pending miss");
			fail_count++;
		end

endmodule

/* test/icache_monitor.sv */
`timescale 1ns/1ps

module icache_monitor (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  icache_pkg::addr_t req_addr,
	input  logic              req_ready,
	input  logic              resp_valid,
	input  icache_pkg::inst_t resp_inst,
	input  logic              resp_ready,
	input  logic              wb_cyc,
	input  logic              check_latency,
	output int                errors,
	output int                refills,
	output int                responses,
	output int                pending
);

	localparam logic [31:0] MUL_K = 32'h9E37_79B1;
	localparam logic [31:0] XOR_K = 32'h5A5A_C3C3;

	icache_pkg::addr_t addr_q [$];  // Accepted, not yet answered
	logic              cyc_q;
	logic              acc_q;

	function automatic icache_pkg::inst_t expected_word(icache_pkg::addr_t a);
		return ((a >> 2) * MUL_K) ^ XOR_K;
	endfunction

	always @(posedge clk) begin
		icache_pkg::addr_t a;
		if (rst) begin
			addr_q.delete();
			errors    = 0;
			refills   = 0;
			responses = 0;
			cyc_q     = 1'b0;
			acc_q     = 1'b0;
		end else begin
			if (req_valid && req_ready) begin
				addr_q.push_back(req_addr);
			end
			if (resp_valid && resp_ready) begin
				responses++;
				if (addr_q.size() == 0) begin
					$display("Response at %0t arrived with no request pending", $time);
					errors++;
				end else begin
					a = addr_q.pop_front();
					if (resp_inst !== expected_word(a)) begin
						$display("MISMATCH at %0t: addr %h expected %h got %h",
							$time, a, expected_word(a), resp_inst);
						errors++;
					end
				end
			end
			if (acc_q && !resp_valid) begin  // Hit must answer one cycle on
				$display("Hit at %0t was not answered in the cycle after acceptance", $time);
				errors++;
			end
			if (wb_cyc && !cyc_q) begin
				refills++;
			end
			cyc_q = wb_cyc;
			acc_q = req_valid && req_ready && check_latency;
		end
		pending = addr_q.size();
	end

endmodule

/* test/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb;

	localparam int CLK_PERIOD = 20;
	localparam int TOTAL_REQS = 290;  // 8 + 32 + 10 + 32 + 8 + 200
	localparam logic [31:0] MUL_K = 32'h9E37_79B1;
	localparam logic [31:0] XOR_K = 32'h5A5A_C3C3;

	logic              clk;
	logic              rst;
	logic              flush;
	logic              req_valid;
	icache_pkg::addr_t req_addr;
	logic              req_ready;
	logic              resp_valid;
	icache_pkg::inst_t resp_inst;
	logic              resp_ready;
	logic              wb_cyc;
	logic              wb_stb;
	icache_pkg::addr_t wb_adr;
	logic              wb_ack;
	icache_pkg::inst_t wb_dat_r;
	logic              stall_en;
	logic              check_latency;
	int                seed = 26104;
	int                ack_delay;
	int                errors;
	int                refills;
	int                responses;
	int                pending;
	int                tb_errors;
	int                err_start;
	int                ref_start;
	int                expected_refills;
	int                model_victim;
	logic [27:0]       model_line  [`ICACHE_SETS][`ICACHE_WAYS];  // Line address per way
	logic              model_valid [`ICACHE_SETS][`ICACHE_WAYS];
	icache_pkg::addr_t order [32];
	icache_pkg::addr_t tmp_addr;
	int                pick;

	icache_top UUT (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_inst  (resp_inst),
		.resp_ready (resp_ready),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_adr     (wb_adr),
		.wb_ack     (wb_ack),
		.wb_dat_r   (wb_dat_r)
	);

	icache_monitor u_monitor (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req_addr      (req_addr),
		.req_ready     (req_ready),
		.resp_valid    (resp_valid),
		.resp_inst     (resp_inst),
		.resp_ready    (resp_ready),
		.wb_cyc        (wb_cyc),
		.check_latency (check_latency),
		.errors        (errors),
		.refills       (refills),
		.responses     (responses),
		.pending       (pending)
	);

	bind icache_top icache_chk u_chk (
		.clk         (clk),
		.rst         (rst),
		.stage_valid (stage_valid),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_inst   (resp_inst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_ack      (wb_ack),
		.wb_adr      (wb_adr)
	);

	function automatic int random_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic icache_pkg::inst_t mem_word(icache_pkg::addr_t a);
		return ((a >> 2) * MUL_K) ^ XOR_K;  // Word index times an odd constant
	endfunction

	function automatic int total_errors();
		return errors + tb_errors + UUT.u_chk.fail_count;
	endfunction

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Wishbone slave, ack after 0 to 3 idle cycles
	initial begin
		wb_ack    = 1'b0;
		wb_dat_r  = '0;
		ack_delay = 0;
		forever begin
			@(negedge clk);
			if (rst || wb_ack) begin
				wb_ack    = 1'b0;
				ack_delay = random_below(4);
			end else if (wb_cyc && wb_stb) begin
				if (ack_delay == 0) begin
					wb_ack   = 1'b1;
					wb_dat_r = mem_word(wb_adr);
				end else begin
					ack_delay--;
				end
			end
		end
	end

	initial begin
		resp_ready = 1'b1;
		forever begin
			@(negedge clk);
			resp_ready = stall_en ? (random_below(4) != 0) : 1'b1;  // Core stalls
		end
	end

	initial begin
		#(TOTAL_REQS * 40 * CLK_PERIOD);
		$display("Run timed out before all tests finished");
		$display("Verification failed");
		$finish;
	end

	// Reference tag store with a round-robin victim
	task automatic model_access(input icache_pkg::addr_t a);
		logic found;
		found = 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_valid[a[7:4]][w] && model_line[a[7:4]][w] == a[31:4]) begin
				found = 1'b1;
			end
		end
		if (!found) begin
			model_line[a[7:4]][model_victim]  = a[31:4];
			model_valid[a[7:4]][model_victim] = 1'b1;
			model_victim = (model_victim + 1) % `ICACHE_WAYS;
			expected_refills++;
		end
	endtask

	task automatic send(input icache_pkg::addr_t a);
		model_access(a);
		req_valid = 1'b1;
		req_addr  = a;
		@(posedge clk);
		while (!req_ready) begin
			@(posedge clk);
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
			end
		end
	endtask

	task automatic begin_test();
		err_start        = total_errors();
		ref_start        = refills;
		expected_refills = 0;
	endtask

	task automatic end_test(input int num, input string name, input bit check_refills);
		int errs;
		@(negedge clk);
		while (pending != 0 || wb_cyc) begin
			@(negedge clk);
		end
		if (check_refills && (refills - ref_start) != expected_refills) begin
			$display("MISMATCH at %0t: test %0d expected %0d refills, saw %0d",
				$time, num, expected_refills, refills - ref_start);
			tb_errors++;
		end
		errs = total_errors() - err_start;
		$display("Test %0d %s: %s, %0d errors, %0d refills", num, name,
			(errs == 0) ? "ok" : "FAILED", errs, refills - ref_start);
	endtask

	initial begin
		rst           = 1'b1;
		flush         = 1'b0;
		req_valid     = 1'b0;
		req_addr      = '0;
		stall_en      = 1'b0;
		check_latency = 1'b0;
		tb_errors     = 0;
		model_victim  = 0;
		for (int s = 0; s < `ICACHE_SETS; s++) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
				model_line[s][w]  = '0;
			end
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		begin_test();
		for (int i = 0; i < 8; i++) begin
			send(32'h2000 + i * 16 + 4 * random_below(4));  // Sets 0 to 7
		end
		end_test(1, "cold misses", 1'b1);

		begin_test();
		for (int i = 0; i < 32; i++) begin
			order[i] = 32'h2000 + i * 4;
		end
		for (int i = 31; i > 0; i--) begin
			pick        = random_below(i + 1);
			tmp_addr    = order[i];
			order[i]    = order[pick];
			order[pick] = tmp_addr;
		end
		check_latency = 1'b1;
		for (int i = 0; i < 32; i++) begin
			send(order[i]);
		end
		end_test(2, "hits", 1'b1);
		check_latency = 1'b0;

		begin_test();
		for (int i = 0; i < 10; i++) begin
			send(32'h4030 + (i % 5) * 32'h100 + 4 * random_below(4));  // All in set 3
		end
		end_test(3, "replacement", 1'b1);

		begin_test();
		stall_en = 1'b1;
		for (int i = 0; i < 32; i++) begin
			if (random_below(2) != 0) begin
				send(32'h2000 + 4 * random_below(32));
			end else begin
				send(32'h4030 + 32'h100 * random_below(5));
			end
		end
		end_test(4, "back-pressure", 1'b1);

		begin_test();
		stall_en = 1'b0;
		pulse_flush();
		for (int i = 0; i < 8; i++) begin
			send(32'h2000 + i * 16);
		end
		end_test(5, "flush", 1'b1);

		begin_test();
		stall_en = 1'b1;
		for (int i = 0; i < 200; i++) begin
			repeat (random_below(3)) @(negedge clk);  // Idle gap in req_valid
			if (random_below(16) == 0) begin
				pulse_flush();
			end
			send(32'h8000 + 4 * random_below(256));  // 1 KB window
		end
		end_test(6, "random mix", 1'b0);

		$display("Summary: 6 tests, %0d responses, %0d refills, %0d errors",
			responses, refills, total_errors());
		if (total_errors() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hw
hw/icache_pkg.sv
hw/icache_lookup.sv
hw/icache_way.sv
hw/icache_refill.sv
hw/icache_top.sv
test/icache_chk.sv
test/icache_monitor.sv
test/icache_tb.sv
